// File: source/fetch_pkg.sv
// shared widths, opcode classes and payload structs of the fetch front end, imported by every block
package fetch_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = '0; // first fetch address

    // major opcode field, instr[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;

    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_imm,
        op_reg,
        op_illegal  // anything not listed above
    } opcode_t;

    // one fetched word and where it came from
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_entry_t;

    // payload of the issue port
    typedef struct packed {
        logic [xlen-1:0] pc;
        opcode_t         opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [xlen-1:0] imm;    // sign extended, 0 for reg and illegal
    } decoded_t;

endpackage

// File: source/fetch_unit.sv
// program counter and four-phase instruction memory master feeding the instruction queue
`timescale 1ns/100ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_ack,
    input  logic [xlen-1:0] mem_rdata,
    input  logic            queue_full,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    output logic            mem_req,
    output logic [xlen-1:0] mem_addr,
    output logic            wr_en,
    output fetch_entry_t    wr_entry
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_release
    } state_t;

    state_t          state;
    logic [xlen-1:0] pc;       // next address to fetch
    logic            discard;  // in-flight word is on the wrong path

    // a redirect in the ack cycle kills the word as well
    assign wr_en = (state == st_wait_ack) && mem_ack && !discard && !redirect;

    // mem_addr is held for the whole handshake, so it tags the word
    assign wr_entry = '{pc: mem_addr, instr: mem_rdata};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= st_idle;
            mem_req  <= 1'b0;
            mem_addr <= reset_pc;
            pc       <= reset_pc;
            discard  <= 1'b0;
        end
        else
        begin
            if (redirect)
                pc <= redirect_pc;
            else if (wr_en)
                pc <= pc + xlen'(4);

            case (state)
                st_idle:
                begin
                    // one fetch in flight at most
                    if (!mem_ack && !queue_full)
                    begin
                        mem_req  <= 1'b1;
                        mem_addr <= redirect ? redirect_pc : pc;
                        discard  <= 1'b0;
                        state    <= st_wait_ack;
                    end
                end

                st_wait_ack:
                begin
                    if (redirect)
                        discard <= 1'b1;  // let the handshake finish, drop the data
                    if (mem_ack)
                    begin
                        mem_req <= 1'b0;
                        state   <= st_wait_release;
                    end
                end

                st_wait_release:
                begin
                    if (!mem_ack)
                        state <= st_idle;  // memory has released the bus
                end

                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: source/instr_queue.sv
// circular FIFO of fetch entries between fetch and decode, with registered reads and flush
`timescale 1ns/100ps

module instr_queue
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8  // power of two, holds QUEUE_DEPTH-1 entries
)
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         wr_en,
    input  fetch_entry_t wr_entry,
    input  logic         rd_en,
    output logic         empty,
    output logic         full,
    output fetch_entry_t rd_entry,
    output logic         rd_valid
);

    localparam int ptr_w = $clog2(QUEUE_DEPTH);

    fetch_entry_t     mem [QUEUE_DEPTH];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] wr_ptr_next;
    logic [ptr_w-1:0] rd_ptr_next;
    logic             do_write;
    logic             do_read;

    // pointers wrap naturally at the power-of-two depth
    assign wr_ptr_next = wr_ptr + 1'b1;
    assign rd_ptr_next = rd_ptr + 1'b1;

    // one slot stays unused so full and empty differ
    assign empty = (rd_ptr == wr_ptr);
    assign full  = (wr_ptr_next == rd_ptr);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // control state
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            rd_valid <= 1'b0;  // no response in a flush cycle
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr_next;
            if (do_read)
                rd_ptr <= rd_ptr_next;
            rd_valid <= do_read;  // one-cycle response pulse
        end
    end

    // storage and read data
    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= wr_entry;
        if (do_read)
            rd_entry <= mem[rd_ptr];
    end

endmodule

// File: source/instr_decode.sv
// pops the instruction queue, decodes each word, resolves jal and issues over a four-phase port
`timescale 1ns/100ps

module instr_decode
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            empty,
    input  fetch_entry_t    rd_entry,
    input  logic            rd_valid,
    input  logic            issue_ack,
    output logic            rd_en,
    output logic            redirect,
    output logic [xlen-1:0] redirect_pc,
    output logic            issue_req,
    output decoded_t        issue_data
);

    typedef enum logic [1:0] {
        st_pop,
        st_wait_data,
        st_issue,
        st_release
    } state_t;

    state_t          state;
    decoded_t        dec;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign instr = rd_entry.instr;

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        dec.pc  = rd_entry.pc;
        dec.rd  = instr[11:7];   // raw fields, whatever the class
        dec.rs1 = instr[19:15];
        dec.imm = '0;
        case (instr[6:0])
            opc_lui:    begin dec.opcode = op_lui;    dec.imm = imm_u; end
            opc_auipc:  begin dec.opcode = op_auipc;  dec.imm = imm_u; end
            opc_jal:    begin dec.opcode = op_jal;    dec.imm = imm_j; end
            opc_jalr:   begin dec.opcode = op_jalr;   dec.imm = imm_i; end
            opc_branch: begin dec.opcode = op_branch; dec.imm = imm_b; end
            opc_load:   begin dec.opcode = op_load;   dec.imm = imm_i; end
            opc_store:  begin dec.opcode = op_store;  dec.imm = imm_s; end
            opc_imm:    begin dec.opcode = op_imm;    dec.imm = imm_i; end
            opc_reg:    dec.opcode = op_reg;
            default:    dec.opcode = op_illegal;
        endcase
    end

    assign rd_en = (state == st_pop) && !empty;

    // jal redirects as its issue handshake closes
    assign redirect    = (state == st_release) && !issue_ack && (issue_data.opcode == op_jal);
    assign redirect_pc = issue_data.pc + issue_data.imm;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= st_pop;
            issue_req <= 1'b0;
        end
        else
        begin
            case (state)
                st_pop:
                    if (rd_en)
                        state <= st_wait_data;
                st_wait_data:
                begin
                    if (rd_valid)
                    begin
                        issue_req <= 1'b1;
                        state     <= st_issue;
                    end
                end
                st_issue:
                begin
                    if (issue_ack)
                    begin
                        issue_req <= 1'b0;
                        state     <= st_release;
                    end
                end
                st_release:
                    if (!issue_ack)
                        state <= st_pop;  // queue already flushed after a jal
                default:
                    state <= st_pop;
            endcase
        end
    end

    // issue payload, held stable through the handshake
    always_ff @(posedge clk)
    begin
        if (state == st_wait_data && rd_valid)
            issue_data <= dec;
    end

endmodule

// File: source/frontend_top.sv
// fetch front end top level, wiring fetch unit, instruction queue and decode together
`timescale 1ns/100ps

module frontend_top
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_ack,
    input  logic [xlen-1:0] mem_rdata,
    input  logic            issue_ack,
    output logic            mem_req,
    output logic [xlen-1:0] mem_addr,
    output logic            issue_req,
    output decoded_t        issue_data
);

    logic            queue_full;
    logic            queue_empty;
    logic            wr_en;
    fetch_entry_t    wr_entry;
    logic            rd_en;
    fetch_entry_t    rd_entry;
    logic            rd_valid;
    logic            redirect;      // also flushes the queue
    logic [xlen-1:0] redirect_pc;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .queue_full  (queue_full),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry)
    );

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk      (clk),
        .rst      (rst),
        .flush    (redirect),
        .wr_en    (wr_en),
        .wr_entry (wr_entry),
        .rd_en    (rd_en),
        .empty    (queue_empty),
        .full     (queue_full),
        .rd_entry (rd_entry),
        .rd_valid (rd_valid)
    );

    instr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .empty       (queue_empty),
        .rd_entry    (rd_entry),
        .rd_valid    (rd_valid),
        .issue_ack   (issue_ack),
        .rd_en       (rd_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .issue_req   (issue_req),
        .issue_data  (issue_data)
    );

endmodule

// File: sim/frontend_ref.svh
// reference model for the front end testbench, decodes image words and walks the followed path
`ifndef FRONTEND_REF_SVH
`define FRONTEND_REF_SVH

// sign extend the low width bits of a field
function automatic logic [31:0] sext(input logic [31:0] value, input int width);
    logic [31:0] upper;
    upper = 32'hffff_ffff << width;
    if (value[width-1])
        return value | upper;
    return value & ~upper;
endfunction

// RV32I major opcode classes and immediate formats
function automatic decoded_t ref_decode(input logic [31:0] pc, input logic [31:0] word);
    decoded_t d;
    d.pc     = pc;
    d.rd     = word[11:7];
    d.rs1    = word[19:15];
    d.imm    = '0;   // reg and illegal keep 0
    d.opcode = op_illegal;
    case (word[6:0])
        7'h37:
        begin
            d.opcode = op_lui;
            d.imm    = {word[31:12], 12'h000};
        end
        7'h17:
        begin
            d.opcode = op_auipc;
            d.imm    = {word[31:12], 12'h000};
        end
        7'h6f:
        begin
            d.opcode = op_jal;
            d.imm    = sext({word[31], word[19:12], word[20], word[30:21], 1'b0}, 21);
        end
        7'h67:
        begin
            d.opcode = op_jalr;
            d.imm    = sext(word[31:20], 12);
        end
        7'h63:
        begin
            d.opcode = op_branch;
            d.imm    = sext({word[31], word[7], word[30:25], word[11:8], 1'b0}, 13);
        end
        7'h03:
        begin
            d.opcode = op_load;
            d.imm    = sext(word[31:20], 12);
        end
        7'h23:
        begin
            d.opcode = op_store;
            d.imm    = sext({word[31:25], word[11:7]}, 12);
        end
        7'h13:
        begin
            d.opcode = op_imm;
            d.imm    = sext(word[31:20], 12);
        end
        7'h33:
            d.opcode = op_reg;
        default:
            d.opcode = op_illegal;
    endcase
    return d;
endfunction

// expected payload of the index-th issue after reset
function automatic decoded_t expected_issue(input int index);
    logic [31:0] pc;
    decoded_t    d;
    pc = reset_pc;
    for (int i = 0; i < index; i++)
    begin
        d = ref_decode(pc, prog[pc[9:2]]);
        if (d.opcode == op_jal)
            pc = pc + d.imm;  // jal is followed
        else
            pc = pc + 32'd4;  // branches and jalr fall through
    end
    return ref_decode(pc, prog[pc[9:2]]);
endfunction

`endif

// File: sim/frontend_tb.sv
// testbench for the fetch front end, random program image with memory responder and issue consumer
`timescale 1ns/100ps

module frontend_tb
    import fetch_pkg::*;
();

    localparam int first_section = 16;  // words with no jal, sequential from reset
    localparam int run_a         = 30;  // issues before the mid-run reset
    localparam int run_b         = 60;  // slow consumer
    localparam int run_c         = 60;  // slow memory
    localparam int total_issues  = run_a + run_b + run_c;
    localparam int max_cycles    = 200 * total_issues + 32;

    logic            clk;
    logic            rst;
    logic            mem_ack;
    logic [xlen-1:0] mem_rdata;
    logic            issue_ack;
    logic            mem_req;
    logic [xlen-1:0] mem_addr;
    logic            issue_req;
    decoded_t        issue_data;

    logic [31:0] prog [256];     // program image, word addressed
    int          seed          = 28507;
    int          mem_seed      = 28507;
    int          ack_seed      = 28507;
    int          mem_delay_max = 5;
    int          ack_delay_max = 5;
    int          issue_count   = 0;
    int          cycle_count   = 0;
    logic [9:0]  seen_class    = '0;
    decoded_t    prev_issue;
    logic        have_prev     = 1'b0;
    int          missing;

    `include "frontend_ref.svh"

    frontend_top #(
        .QUEUE_DEPTH (4)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .issue_ack  (issue_ack),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .issue_req  (issue_req),
        .issue_data (issue_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles)
        begin
            $display("issue stream stalled, only %0d issues after %0d cycles",
                     issue_count, cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped");
        end
    endtask

    // encode one word of the given class from random bits
    function automatic logic [31:0] make_word(input opcode_t cls, input logic [31:0] bits);
        logic [6:0] opc;
        int         words;
        case (cls)
            op_lui:    opc = 7'h37;
            op_auipc:  opc = 7'h17;
            op_jal:    opc = 7'h6f;
            op_jalr:   opc = 7'h67;
            op_branch: opc = 7'h63;
            op_load:   opc = 7'h03;
            op_store:  opc = 7'h23;
            op_imm:    opc = 7'h13;
            op_reg:    opc = 7'h33;
            default:   opc = bits[0] ? 7'h0f : 7'h7f;  // fence and a reserved code
        endcase
        if (cls == op_jal)
        begin
            words = 1 + bits[31:28];  // forward 1 to 16 words
            return {1'b0, 10'(words * 2), 1'b0, 8'h00, bits[11:7], opc};
        end
        return {bits[31:7], opc};
    endfunction

    task automatic build_image();
        int      sel;
        opcode_t cls;
        logic [31:0] bits;
        for (int i = 0; i < 256; i++)
        begin
            bits = $random(seed);
            if (i < first_section)
            begin
                sel = i % 9;
                cls = (sel >= 2) ? opcode_t'(sel + 1) : opcode_t'(sel);  // skips jal
            end
            else
            begin
                sel = {$random(seed)} % 11;
                cls = (sel > 9) ? op_illegal : opcode_t'(sel);
            end
            prog[i] = make_word(cls, bits);
        end
    endtask

    task automatic check_issue(input decoded_t got);
        decoded_t exp;
        exp = expected_issue(issue_count);
        if (issue_count < first_section)
            check_value("issue_data.pc sequential", got.pc, issue_count * 4);
        if (have_prev && prev_issue.opcode == op_jal)
            check_value("issue_data.pc jal target", got.pc, prev_issue.pc + prev_issue.imm);
        check_value("issue_data.pc", got.pc, exp.pc);
        check_value("issue_data.opcode", 32'(got.opcode), 32'(exp.opcode));
        check_value("issue_data.rd", 32'(got.rd), 32'(exp.rd));
        check_value("issue_data.rs1", 32'(got.rs1), 32'(exp.rs1));
        check_value("issue_data.imm", got.imm, exp.imm);
        seen_class[got.opcode] = 1'b1;
        prev_issue  = exp;
        have_prev   = 1'b1;
        issue_count = issue_count + 1;
    endtask

    // instruction memory slave, four-phase
    initial
    begin : mem_responder
        int delay;
        forever
        begin
            @(negedge clk);
            if (!rst && mem_req && !mem_ack)
            begin
                delay = {$random(mem_seed)} % (mem_delay_max + 1);
                repeat (delay) @(negedge clk);
                if (!rst && mem_req)
                begin
                    mem_rdata = prog[mem_addr[9:2]];  // wraps at 256 words
                    mem_ack   = 1'b1;
                    do @(negedge clk); while (mem_req);
                    mem_ack = 1'b0;
                end
            end
        end
    end

    // back end side of the issue port, compares every payload
    initial
    begin : issue_consumer
        int delay;
        forever
        begin
            @(negedge clk);
            if (!rst && issue_req && !issue_ack)
            begin
                delay = {$random(ack_seed)} % (ack_delay_max + 1);
                repeat (delay) @(negedge clk);
                if (!rst && issue_req)
                begin
                    check_issue(issue_data);
                    issue_ack = 1'b1;
                    do @(negedge clk); while (issue_req);
                    issue_ack = 1'b0;
                end
            end
        end
    end

    task automatic wait_issues(input int count);
        while (issue_count < count)
            @(posedge clk);
    endtask

    task automatic report_classes(output int absent);
        opcode_t op;
        absent = 0;
        for (int c = 0; c < 10; c++)
        begin
            op = opcode_t'(c);
            if (!seen_class[c])
            begin
                $display("opcode class %s was never issued", op.name());
                absent = absent + 1;
            end
        end
    endtask

    initial
    begin : main_sequence
        rst       = 1'b1;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        issue_ack = 1'b0;
        build_image();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        wait_issues(run_a);

        // reset in the middle of the stream
        @(negedge clk);
        rst = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("issue_req in reset", 32'(issue_req), 32'd0);
        check_value("mem_req in reset", 32'(mem_req), 32'd0);
        repeat (7) @(negedge clk);
        issue_count = 0;   // stream restarts at index 0
        have_prev   = 1'b0;
        rst         = 1'b0;

        ack_delay_max = 20;  // decode stalls, queue fills
        mem_delay_max = 5;
        wait_issues(run_b);

        ack_delay_max = 2;
        mem_delay_max = 8;
        wait_issues(run_b + run_c);

        report_classes(missing);
        if (missing != 0)
        begin
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped");
        end
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+sim
source/fetch_pkg.sv
source/fetch_unit.sv
source/instr_queue.sv
source/instr_decode.sv
source/frontend_top.sv
sim/frontend_tb.sv
